// ==== Makefile ====
# Verilator build and run for the branch target buffer testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= BtbTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
src/BtbPkg.sv
src/BtbReadIf.sv
src/BtbFetchDecode.sv
src/BtbEntryArray.sv
src/BtbUpdateQueue.sv
src/BtbHitResolve.sv
src/BranchTargetBuffer.sv
test/BtbTb.sv

// ==== src/BranchTargetBuffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the two-wide branch target buffer.
// Lookups return one cycle after the fetch PC; updates are credit-based
// and start once initDone is high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BranchTargetBuffer #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rstN,

    // Fetch lookup.
    input  logic          fetchValid,
    input  BtbPkg::PcPath fetchPc,

    // Resolved taken branches.
    input  logic          updValid       [BtbPkg::UPDATE_WIDTH],
    input  BtbPkg::PcPath updBrAddr      [BtbPkg::UPDATE_WIDTH],
    input  BtbPkg::PcPath updTarget      [BtbPkg::UPDATE_WIDTH],
    input  logic          updIsCondBr    [BtbPkg::UPDATE_WIDTH],

    output logic          initDone,
    output logic          creditReturn,

    // Prediction, one cycle after the fetch PC.
    output logic          lookupHit      [BtbPkg::FETCH_WIDTH],
    output BtbPkg::PcPath lookupTarget   [BtbPkg::FETCH_WIDTH],
    output logic          lookupIsCondBr [BtbPkg::FETCH_WIDTH]
);
    import BtbPkg::*;

    logic    writeEnable;
    BtbIndex writeIndex;
    BtbEntry writeEntry;

    BtbReadIf readIf ();

    BtbFetchDecode fetchDecode (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .readPort   (readIf.decodePort)
    );

    BtbEntryArray entryArray (
        .clk         (clk),
        .readPort    (readIf.arrayPort),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeEntry  (writeEntry)
    );

    BtbUpdateQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) updateQueue (
        .clk          (clk),
        .rstN         (rstN),
        .updValid     (updValid),
        .updBrAddr    (updBrAddr),
        .updTarget    (updTarget),
        .updIsCondBr  (updIsCondBr),
        .initDone     (initDone),
        .creditReturn (creditReturn),
        .writeEnable  (writeEnable),
        .writeIndex   (writeIndex),
        .writeEntry   (writeEntry)
    );

    BtbHitResolve hitResolve (
        .readPort       (readIf.resultPort),
        .initDone       (initDone),
        .lookupHit      (lookupHit),
        .lookupTarget   (lookupTarget),
        .lookupIsCondBr (lookupIsCondBr)
    );

endmodule

// ==== src/BtbEntryArray.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Entry storage of the branch target buffer.
// Two synchronous read ports and one write port; a read of the entry
// being written in the same cycle returns the new value.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BtbEntryArray (
    input  logic            clk,
    BtbReadIf.arrayPort     readPort,
    input  logic            writeEnable,
    input  BtbPkg::BtbIndex writeIndex,
    input  BtbPkg::BtbEntry writeEntry
);
    import BtbPkg::*;

    BtbEntry entries [ENTRY_NUM];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // Registered reads, bypassing the write on an index match.
    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (writeEnable && (writeIndex == readPort.readIndex[i])) begin
                readPort.readEntry[i] <= writeEntry;
            end
            else begin
                readPort.readEntry[i] <= entries[readPort.readIndex[i]];
            end
        end
    end

endmodule

// ==== src/BtbFetchDecode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch decode for the branch target buffer.
// Splits the fetch PC into one read index per slot and keeps the slot
// PCs for the tag compare in the following cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BtbFetchDecode (
    input  logic            clk,
    input  logic            rstN,
    input  logic            fetchValid,
    input  BtbPkg::PcPath   fetchPc,
    BtbReadIf.decodePort    readPort
);
    import BtbPkg::*;

    localparam int INSN_BYTES = 4;

    PcPath slotAddr [FETCH_WIDTH];

    // Slot i looks up the i-th instruction after the fetch PC.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slotAddr[i] = fetchPc + PcPath'(INSN_BYTES * i);
            readPort.readIndex[i] = toBtbIndex(slotAddr[i]);
        end
    end

    // Slot PCs line up with the registered read data.
    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            readPort.slotPc[i] <= slotAddr[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPort.lookupValid <= 1'b0;
        end
        else begin
            readPort.lookupValid <= fetchValid;
        end
    end

endmodule

// ==== src/BtbHitResolve.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hit resolution for the branch target buffer.
// Compares stored tags with the registered slot PCs and rebuilds the
// full predicted targets.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BtbHitResolve (
    BtbReadIf.resultPort  readPort,
    input  logic          initDone,
    output logic          lookupHit      [BtbPkg::FETCH_WIDTH],
    output BtbPkg::PcPath lookupTarget   [BtbPkg::FETCH_WIDTH],
    output logic          lookupIsCondBr [BtbPkg::FETCH_WIDTH]
);
    import BtbPkg::*;

    logic tagMatch [FETCH_WIDTH];

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            tagMatch[i] = readPort.readEntry[i].tag == toBtbTag(readPort.slotPc[i]);

            // No hits while the sweep is still clearing entries.
            lookupHit[i] = readPort.readEntry[i].valid && tagMatch[i]
                        && readPort.lookupValid && initDone;

            lookupTarget[i] = rebuildTarget(readPort.slotPc[i],
                                            readPort.readEntry[i].target);
            lookupIsCondBr[i] = readPort.readEntry[i].isCondBr;
        end
    end

endmodule

// ==== src/BtbPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the branch target buffer.
// Address layout, the stored entry format and the PC field helpers.
// Each block imports what it needs from here.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package BtbPkg;

    localparam int PC_BITS      = 32;
    localparam int FETCH_WIDTH  = 2;
    localparam int UPDATE_WIDTH = 2;
    localparam int INDEX_BITS   = 6;
    localparam int TAG_BITS     = 10;
    localparam int TARGET_BITS  = 16;
    localparam int ENTRY_NUM    = 1 << INDEX_BITS;

    typedef logic [PC_BITS-1:0]     PcPath;
    typedef logic [INDEX_BITS-1:0]  BtbIndex;
    typedef logic [TAG_BITS-1:0]    BtbTag;
    typedef logic [TARGET_BITS-1:0] BtbTarget;

    // One buffer entry, 28 bits wide.
    typedef struct packed {
        logic     valid;
        logic     isCondBr;
        BtbTag    tag;
        BtbTarget target;
    } BtbEntry;

    // Index is the word address above the byte offset.
    function automatic BtbIndex toBtbIndex(input PcPath pc);
        return pc[INDEX_BITS+1:2];
    endfunction

    // Tag sits right above the index.
    function automatic BtbTag toBtbTag(input PcPath pc);
        return pc[TAG_BITS+INDEX_BITS+1:INDEX_BITS+2];
    endfunction

    // Low word-address bits of the target are kept.
    function automatic BtbTarget toBtbTarget(input PcPath pc);
        return pc[TARGET_BITS+1:2];
    endfunction

    // Upper bits come from the PC that looked the entry up.
    function automatic PcPath rebuildTarget(input PcPath pc, input BtbTarget target);
        return {pc[PC_BITS-1:TARGET_BITS+2], target, 2'b00};
    endfunction

endpackage

// ==== src/BtbReadIf.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read path of the branch target buffer.
// Decode drives the indices and slot PCs, the array returns the entries
// and the result stage compares them.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface BtbReadIf;
    import BtbPkg::*;

    BtbIndex readIndex [FETCH_WIDTH];
    BtbEntry readEntry [FETCH_WIDTH];
    PcPath   slotPc    [FETCH_WIDTH];
    logic    lookupValid;

    modport decodePort (
        output readIndex, slotPc, lookupValid
    );

    modport arrayPort (
        input  readIndex,
        output readEntry
    );

    modport resultPort (
        input readEntry, slotPc, lookupValid
    );

endinterface

// ==== src/BtbUpdateQueue.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Update path of the branch target buffer.
// Clears the array after reset, then queues taken-branch updates from two
// lanes and drains them one per cycle, returning a credit on each write.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BtbUpdateQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            updValid    [BtbPkg::UPDATE_WIDTH],
    input  BtbPkg::PcPath   updBrAddr   [BtbPkg::UPDATE_WIDTH],
    input  BtbPkg::PcPath   updTarget   [BtbPkg::UPDATE_WIDTH],
    input  logic            updIsCondBr [BtbPkg::UPDATE_WIDTH],
    output logic            initDone,
    output logic            creditReturn,
    output logic            writeEnable,
    output BtbPkg::BtbIndex writeIndex,
    output BtbPkg::BtbEntry writeEntry
);
    import BtbPkg::*;

    localparam int PTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_BITS-1:0]   QueuePtr;
    typedef logic [COUNT_BITS-1:0] QueueCount;

    BtbIndex   queueIndex [QUEUE_DEPTH];
    BtbEntry   queueEntry [QUEUE_DEPTH];
    QueuePtr   headPtr;
    QueuePtr   tailPtr;
    QueuePtr   pushPtr;
    QueueCount count;
    QueueCount pushCount;
    logic      popValid;
    BtbIndex   sweepIndex;
    logic      pushEnable [UPDATE_WIDTH];
    QueuePtr   pushSlot   [UPDATE_WIDTH];
    BtbIndex   laneIndex  [UPDATE_WIDTH];
    BtbEntry   laneEntry  [UPDATE_WIDTH];

    // Wraps for depths that are not a power of two.
    function automatic QueuePtr nextPtr(input QueuePtr ptr);
        return (ptr == QueuePtr'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Lane 0 takes the tail slot first, lane 1 the one after.
    always_comb begin
        pushPtr   = tailPtr;
        pushCount = '0;
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            pushEnable[i]         = initDone && updValid[i];
            pushSlot[i]           = pushPtr;
            laneIndex[i]          = toBtbIndex(updBrAddr[i]);
            laneEntry[i].valid    = 1'b1;
            laneEntry[i].isCondBr = updIsCondBr[i];
            laneEntry[i].tag      = toBtbTag(updBrAddr[i]);
            laneEntry[i].target   = toBtbTarget(updTarget[i]);
            if (pushEnable[i]) begin
                pushPtr   = nextPtr(pushPtr);
                pushCount = pushCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            if (pushEnable[i]) begin
                queueIndex[pushSlot[i]] <= laneIndex[i];
                queueEntry[pushSlot[i]] <= laneEntry[i];
            end
        end
    end

    // Sweep owns the write port until initDone, the queue head after.
    assign popValid     = initDone && (count != '0);
    assign creditReturn = popValid;
    assign writeEnable  = !initDone || popValid;
    assign writeIndex   = initDone ? queueIndex[headPtr] : sweepIndex;
    assign writeEntry   = initDone ? queueEntry[headPtr] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweepIndex <= '0;
            initDone   <= 1'b0;
            headPtr    <= '0;
            tailPtr    <= '0;
            count      <= '0;
        end
        else begin
            if (!initDone) begin
                sweepIndex <= sweepIndex + 1'b1;
                if (sweepIndex == BtbIndex'(ENTRY_NUM - 1)) begin
                    initDone <= 1'b1;
                end
            end
            if (popValid) begin
                headPtr <= nextPtr(headPtr);
            end
            tailPtr <= pushPtr;
            count   <= count + pushCount - QueueCount'(popValid);
        end
    end

endmodule

// ==== test/BtbTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the branch target buffer.
// Replays update and lookup records from the stimulus file, keeps the
// update credits and checks every lookup against the expected results.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module BtbTb;
    import BtbPkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int RESET_CYCLES = 5;
    localparam int REC_WORDS    = 6;
    localparam int MAX_RECORDS  = 64;

    logic  clk;
    logic  rstN;
    logic  fetchValid;
    PcPath fetchPc;
    logic  updValid       [UPDATE_WIDTH];
    PcPath updBrAddr      [UPDATE_WIDTH];
    PcPath updTarget      [UPDATE_WIDTH];
    logic  updIsCondBr    [UPDATE_WIDTH];
    logic  initDone;
    logic  creditReturn;
    logic  lookupHit      [FETCH_WIDTH];
    PcPath lookupTarget   [FETCH_WIDTH];
    logic  lookupIsCondBr [FETCH_WIDTH];

    logic [31:0] stimWords [MAX_RECORDS * REC_WORDS];
    int recordCount  = 0;
    int timeoutLimit = 0;
    int cycleCount   = 0;
    int sentCount    = 0;
    int returnedCount = 0;
    int sweepCycles;

    BranchTargetBuffer #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk            (clk),
        .rstN           (rstN),
        .fetchValid     (fetchValid),
        .fetchPc        (fetchPc),
        .updValid       (updValid),
        .updBrAddr      (updBrAddr),
        .updTarget      (updTarget),
        .updIsCondBr    (updIsCondBr),
        .initDone       (initDone),
        .creditReturn   (creditReturn),
        .lookupHit      (lookupHit),
        .lookupTarget   (lookupTarget),
        .lookupIsCondBr (lookupIsCondBr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic int creditsHeld();
        return QUEUE_DEPTH - sentCount + returnedCount;
    endfunction

    task automatic clearUpdates();
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            updValid[i] <= 1'b0;
        end
    endtask

    // Sends one update group once enough credits are held.
    task automatic runUpdate(input int rec);
        logic [15:0] flags;
        int base;
        int lanes;
        base  = rec * REC_WORDS;
        flags = stimWords[base + 1][15:0];
        lanes = int'(flags[12]) + int'(flags[4]);
        @(posedge clk);
        while (creditsHeld() < lanes) begin
            clearUpdates();
            @(posedge clk);
        end
        updValid[0]    <= flags[12];
        updIsCondBr[0] <= flags[8];
        updBrAddr[0]   <= stimWords[base + 2];
        updTarget[0]   <= stimWords[base + 3];
        updValid[1]    <= flags[4];
        updIsCondBr[1] <= flags[0];
        updBrAddr[1]   <= stimWords[base + 4];
        updTarget[1]   <= stimWords[base + 5];
        sentCount += lanes;
    endtask

    // A lookup waits until every queued update has been written.
    task automatic runLookup(input int rec);
        logic [15:0] flags;
        logic        expHit  [FETCH_WIDTH];
        logic        expCond [FETCH_WIDTH];
        PcPath       expTarget [FETCH_WIDTH];
        int base;
        base         = rec * REC_WORDS;
        flags        = stimWords[base + 1][15:0];
        expHit[0]    = flags[12];
        expCond[0]   = flags[8];
        expHit[1]    = flags[4];
        expCond[1]   = flags[0];
        expTarget[0] = stimWords[base + 3];
        expTarget[1] = stimWords[base + 4];
        do begin
            @(posedge clk);
            clearUpdates();
        end while (returnedCount != sentCount);
        fetchValid <= 1'b1;
        fetchPc    <= stimWords[base + 2];
        @(posedge clk);
        fetchValid <= 1'b0;
        @(negedge clk);
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            checkValue($sformatf("record %0d slot %0d hit", rec, s), 32'(expHit[s]),
                       32'(lookupHit[s]));
            if (expHit[s]) begin
                checkValue($sformatf("record %0d slot %0d target", rec, s), expTarget[s],
                           lookupTarget[s]);
                checkValue($sformatf("record %0d slot %0d cond", rec, s), 32'(expCond[s]),
                           32'(lookupIsCondBr[s]));
            end
        end
    endtask

    // Credit pulses are counted in the middle of the cycle.
    always @(negedge clk) begin
        if (rstN && creditReturn) begin
            if (returnedCount >= sentCount) begin
                failRun("Credit returned while no update was outstanding");
            end
            else begin
                returnedCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            failRun($sformatf("Timeout after %0d cycles with %0d of %0d credits returned",
                              cycleCount, returnedCount, sentCount));
        end
    end

    initial begin
        rstN       = 1'b0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            updValid[i]    = 1'b0;
            updBrAddr[i]   = '0;
            updTarget[i]   = '0;
            updIsCondBr[i] = 1'b0;
        end

        $readmemh("test/btb_stimulus.txt", stimWords);
        while (recordCount < MAX_RECORDS && stimWords[recordCount * REC_WORDS] !== 32'h0) begin
            recordCount++;
        end
        if (recordCount == 0) begin
            failRun("No records found in the stimulus file");
        end
        timeoutLimit = 100 + 40 * recordCount;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        checkValue("initDone in reset", 32'h0, 32'(initDone));
        checkValue("creditReturn in reset", 32'h0, 32'(creditReturn));
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            checkValue($sformatf("slot %0d hit in reset", s), 32'h0, 32'(lookupHit[s]));
        end
        @(posedge clk);
        rstN <= 1'b1;

        // The sweep clears one entry per cycle.
        sweepCycles = 0;
        @(negedge clk);
        while (!initDone) begin
            sweepCycles++;
            @(negedge clk);
        end
        checkValue("sweep length", 32'(ENTRY_NUM), 32'(sweepCycles));

        for (int rec = 0; rec < recordCount; rec++) begin
            case (stimWords[rec * REC_WORDS])
                32'h1: runUpdate(rec);
                32'h2: runLookup(rec);
                default: failRun($sformatf("Unknown record kind in record %0d", rec));
            endcase
        end

        do begin
            @(posedge clk);
            clearUpdates();
        end while (returnedCount != sentCount);
        // A stray credit pulse in this window is caught by the credit counter.
        repeat (2 * QUEUE_DEPTH) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== test/btb_stimulus.txt ====
// Six hex words per record: kind flags a b c d. Kind 1 update, 2 lookup, 0 end.
// Update: flags = valid0 cond0 valid1 cond1 nibbles, a/b lane 0 branch/target, c/d lane 1.
// Lookup: flags = hit0 cond0 hit1 cond1 nibbles, a fetch PC, b/c expected targets, d unused.
// Empty buffer after the sweep.
2 0000 00400000 00000000 00000000 00000000
2 0000 00400040 00000000 00000000 00000000
2 0000 004000F8 00000000 00000000 00000000
2 0000 00412380 00000000 00000000 00000000
// Single update, seen from slot 0 and from slot 1.
1 1100 00400010 00401234 00000000 00000000
2 1100 00400010 00401234 00000000 00000000
2 0011 0040000C 00000000 00401234 00000000
// Two lanes in one cycle, target rebuilt from the upper PC bits.
1 1011 00400020 12345678 00400024 00400100
2 1011 00400020 00405678 00400100 00000000
// Same index, other tag.
2 0000 00400110 00000000 00000000 00000000
1 1000 00400110 00402000 00000000 00000000
2 1000 00400110 00402000 00000000 00000000
2 0000 00400010 00000000 00000000 00000000
// Both lanes on one index, lane 1 lands last.
1 1110 00400030 00403000 00400030 00404000
2 1000 00400030 00404000 00000000 00000000
1 1011 00400040 00400900 00400240 00400A00
2 0000 00400040 00000000 00000000 00000000
2 1100 00400240 00400A00 00000000 00000000
// Burst of four updates back to back.
1 1010 00400050 00400500 00400054 00400540
1 1111 00400058 00400580 0040005C 004005C0
2 1010 00400050 00400500 00400540 00000000
2 1111 00400058 00400580 004005C0 00000000
// Partial tag, upper target bits follow the fetch PC.
1 1100 00400060 00400700 00000000 00000000
2 1100 00C00060 00C00700 00000000 00000000
// Slot 1 crosses into the next tag.
1 1000 00400100 00400800 00000000 00000000
2 0010 004000FC 00000000 00400800 00000000
0 0000 00000000 00000000 00000000 00000000
